// ==== port_isolate.f ====
src/axil_pkg.sv
src/isolate_cfg_pkg.sv
src/write_isolate.sv
src/read_isolate.sv
src/isolate_ctrl.sv
src/port_isolate.sv
testbench/tb_clock_gen.sv
testbench/tb_port_isolate.sv

// ==== testbench/tb_port_isolate.sv ====
/*
  Testbench for the port isolation gate. Issues random single-beat reads
  and writes, answers them from a downstream target model and checks each
  upstream response against the expectation recorded when it was issued.
*/
`timescale 1ns/1ps

module tb_port_isolate
  import axil_pkg::*;
();

  localparam int NumPending    = 4;
  localparam int NumTraffic    = 10;
  localparam int NumHeld       = 3;
  localparam int TotalTxn      = 2 * (3 * NumTraffic + NumPending + NumHeld + 2);
  localparam int TimeoutCycles = TotalTxn * 40;

  logic clk_i, rst_n_i, isolate_i, isolated_o;
  logic s_aw_valid_i, s_aw_ready_o, s_b_valid_o, s_b_ready_i;
  logic m_aw_valid_o, m_aw_ready_i, m_b_valid_i, m_b_ready_o;
  logic s_ar_valid_i, s_ar_ready_o, s_r_valid_o, s_r_ready_i;
  logic m_ar_valid_o, m_ar_ready_i, m_r_valid_i, m_r_ready_o;
  logic [AddrWidth-1:0] s_aw_addr_i, m_aw_addr_o, s_ar_addr_i, m_ar_addr_o;
  logic [DataWidth-1:0] s_aw_data_i, m_aw_data_o, s_r_data_o, m_r_data_i;
  logic [IdWidth-1:0]   s_aw_id_i, m_aw_id_o, s_b_id_o, m_b_id_i;
  logic [IdWidth-1:0]   s_ar_id_i, m_ar_id_o, s_r_id_o, m_r_id_i;
  resp_t                s_b_resp_o, m_b_resp_i, s_r_resp_o, m_r_resp_i;

  logic [31:0]          lfsr_q;
  logic                 hold_rsp, no_fwd;
  logic [IdWidth-1:0]   rd_id_next, wr_id_next;
  logic [AddrWidth-1:0] rd_addr_q[$];
  logic [IdWidth-1:0]   rd_id_q[$], wr_id_q[$];
  logic                 exp_rd_pend[2**IdWidth], exp_wr_pend[2**IdWidth];
  logic [DataWidth-1:0] exp_rd_data[2**IdWidth];
  logic [AddrWidth-1:0] exp_wr_addr[2**IdWidth];
  logic [DataWidth-1:0] exp_wr_data[2**IdWidth];
  resp_t                exp_rd_resp[2**IdWidth], exp_wr_resp[2**IdWidth];
  int                   rd_outstanding, wr_outstanding, dn_rd_cnt, dn_wr_cnt;
  int                   err_cnt, test_err_base, tests_run, tests_failed;
  string                test_name;

  tb_clock_gen i_clock_gen (.clk_o(clk_i));

  port_isolate #(.NumPending(NumPending)) UUT (.*);

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Reference read data is the address XOR the id repeated across the word
  function automatic logic [DataWidth-1:0] expected_rdata(input logic [AddrWidth-1:0] addr,
                                                          input logic [IdWidth-1:0] id);
    return addr ^ {(DataWidth / IdWidth){id}};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("Error in test %s: %s", test_name, msg);
    err_cnt++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_base = err_cnt;
    tests_run++;
  endtask

  task automatic finish_test();
    if (err_cnt == test_err_base) begin
      $display("Test %s: passed", test_name);
    end else begin
      $display("Test %s: failed with %0d errors", test_name, err_cnt - test_err_base);
      tests_failed++;
    end
  endtask

  // Drives one upstream request and records the response it must produce
  task automatic issue_txn(input logic is_read, input logic terminated);
    logic [31:0]        addr;
    logic [31:0]        data;
    logic [IdWidth-1:0] id;
    logic               accepted;
    take_bits(32, addr);
    if (is_read) begin
      id = rd_id_next;
      rd_id_next = rd_id_next + 1'b1;
      exp_rd_pend[id] = 1'b1;
      exp_rd_data[id] = terminated ? '0 : expected_rdata(addr, id);
      exp_rd_resp[id] = terminated ? RespSlvErr : RespOkay;
      rd_outstanding++;
      {s_ar_valid_i, s_ar_addr_i, s_ar_id_i} = {1'b1, addr, id};
    end else begin
      take_bits(32, data);
      id = wr_id_next;
      wr_id_next = wr_id_next + 1'b1;
      exp_wr_pend[id] = 1'b1;
      exp_wr_resp[id] = terminated ? RespSlvErr : RespOkay;
      exp_wr_addr[id] = addr;
      exp_wr_data[id] = data;
      wr_outstanding++;
      {s_aw_valid_i, s_aw_addr_i, s_aw_id_i, s_aw_data_i} = {1'b1, addr, id, data};
    end
    do begin
      @(negedge clk_i);
      accepted = is_read ? s_ar_ready_o : s_aw_ready_o;
      @(posedge clk_i);
      #1;
    end while (!accepted);
    if (is_read)
      s_ar_valid_i = 1'b0;
    else
      s_aw_valid_i = 1'b0;
  endtask

  task automatic run_traffic(input int n, input logic terminated);
    fork
      repeat (n) issue_txn(1'b1, terminated);
      repeat (n) issue_txn(1'b0, terminated);
    join
  endtask

  task automatic wait_all_done();
    do begin
      @(posedge clk_i);
    end while (rd_outstanding != 0 || wr_outstanding != 0);
    #1;
  endtask

  // Downstream target with random ready stalls and in-order answers after random delays
  initial begin : target_model
    logic [31:0]          r;
    logic                 r_done;
    logic                 b_done;
    logic [AddrWidth-1:0] addr;
    logic [IdWidth-1:0]   id;
    forever begin
      @(negedge clk_i);
      if (m_ar_valid_o && m_ar_ready_i) begin
        if (no_fwd)
          report_error("read request forwarded downstream while blocked");
        rd_addr_q.push_back(m_ar_addr_o);
        rd_id_q.push_back(m_ar_id_o);
        dn_rd_cnt++;
      end
      if (m_aw_valid_o && m_aw_ready_i) begin
        if (no_fwd)
          report_error("write request forwarded downstream while blocked");
        if (m_aw_addr_o !== exp_wr_addr[m_aw_id_o])
          report_mismatch("write addr", exp_wr_addr[m_aw_id_o], m_aw_addr_o);
        if (m_aw_data_o !== exp_wr_data[m_aw_id_o])
          report_mismatch("write data", exp_wr_data[m_aw_id_o], m_aw_data_o);
        wr_id_q.push_back(m_aw_id_o);
        dn_wr_cnt++;
      end
      r_done = m_r_valid_i && m_r_ready_o;
      b_done = m_b_valid_i && m_b_ready_o;
      @(posedge clk_i);
      #1;
      if (r_done)
        m_r_valid_i = 1'b0;
      if (b_done)
        m_b_valid_i = 1'b0;
      take_bits(4, r);
      m_ar_ready_i = (r[1:0] != 2'b00);
      m_aw_ready_i = (r[3:2] != 2'b00);
      take_bits(2, r);
      if (r[0] && !m_r_valid_i && !hold_rsp && rd_id_q.size() > 0) begin
        addr = rd_addr_q.pop_front();
        id = rd_id_q.pop_front();
        {m_r_valid_i, m_r_id_i, m_r_resp_i} = {1'b1, id, RespOkay};
        m_r_data_i = expected_rdata(addr, id);
      end
      if (r[1] && !m_b_valid_i && !hold_rsp && wr_id_q.size() > 0) begin
        id = wr_id_q.pop_front();
        {m_b_valid_i, m_b_id_i, m_b_resp_i} = {1'b1, id, RespOkay};
      end
    end
  end

  initial begin : response_check
    logic [31:0]        r;
    logic [IdWidth-1:0] id;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && s_r_valid_o && s_r_ready_i) begin
        id = s_r_id_o;
        if (!exp_rd_pend[id]) begin
          report_error($sformatf("read response with id %0h that no open read carries", id));
        end else begin
          if (s_r_resp_o !== exp_rd_resp[id])
            report_mismatch("read resp", exp_rd_resp[id], s_r_resp_o);
          if (s_r_data_o !== exp_rd_data[id])
            report_mismatch("read data", exp_rd_data[id], s_r_data_o);
          exp_rd_pend[id] = 1'b0;
          rd_outstanding--;
        end
      end
      if (rst_n_i && s_b_valid_o && s_b_ready_i) begin
        id = s_b_id_o;
        if (!exp_wr_pend[id]) begin
          report_error($sformatf("write response with id %0h that no open write carries", id));
        end else begin
          if (s_b_resp_o !== exp_wr_resp[id])
            report_mismatch("write resp", exp_wr_resp[id], s_b_resp_o);
          exp_wr_pend[id] = 1'b0;
          wr_outstanding--;
        end
      end
      @(posedge clk_i);
      #1;
      take_bits(4, r);
      s_r_ready_i = (r[1:0] != 2'b00);
      s_b_ready_i = (r[3:2] != 2'b00);
    end
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main_seq
    int base_rd;
    int base_wr;
    lfsr_q = 32'hd5b2_c7d2;
    {rst_n_i, isolate_i, hold_rsp, no_fwd} = '0;
    {s_aw_valid_i, s_aw_addr_i, s_aw_id_i, s_aw_data_i, s_b_ready_i} = '0;
    {s_ar_valid_i, s_ar_addr_i, s_ar_id_i, s_r_ready_i} = '0;
    {m_aw_ready_i, m_b_valid_i, m_b_id_i, m_b_resp_i} = '0;
    {m_ar_ready_i, m_r_valid_i, m_r_id_i, m_r_data_i, m_r_resp_i} = '0;
    {rd_id_next, wr_id_next} = '0;
    {rd_outstanding, wr_outstanding, dn_rd_cnt, dn_wr_cnt} = '0;
    {err_cnt, tests_run, tests_failed} = '0;
    for (int i = 0; i < 2**IdWidth; i++) begin
      exp_rd_pend[i] = 1'b0;
      exp_wr_pend[i] = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    begin_test("reset_state");
    @(negedge clk_i);
    if (isolated_o !== 1'b0)
      report_mismatch("isolated_o", 0, isolated_o);
    if ({m_aw_valid_o, m_ar_valid_o} !== 2'b00)
      report_mismatch("downstream valids", 0, {m_aw_valid_o, m_ar_valid_o});
    if ({s_b_valid_o, s_r_valid_o} !== 2'b00)
      report_mismatch("upstream response valids", 0, {s_b_valid_o, s_r_valid_o});
    @(posedge clk_i);
    #1;
    finish_test();

    begin_test("pass_through");
    run_traffic(NumTraffic, 1'b0);
    wait_all_done();
    finish_test();

    begin_test("pending_limit");
    hold_rsp = 1'b1;
    base_rd = dn_rd_cnt;
    base_wr = dn_wr_cnt;
    fork
      run_traffic(NumPending + 1, 1'b0);
      begin
        while (dn_rd_cnt - base_rd < NumPending || dn_wr_cnt - base_wr < NumPending)
          @(posedge clk_i);
        repeat (20) begin
          @(negedge clk_i);
          if (s_ar_ready_o || s_aw_ready_o)
            report_error("upstream request ready high with the pending limit reached");
        end
        @(posedge clk_i);
        #1;
        if (dn_rd_cnt - base_rd != NumPending)
          report_mismatch("reads forwarded", NumPending, dn_rd_cnt - base_rd);
        if (dn_wr_cnt - base_wr != NumPending)
          report_mismatch("writes forwarded", NumPending, dn_wr_cnt - base_wr);
        hold_rsp = 1'b0;
      end
    join
    wait_all_done();
    finish_test();

    // Responses held downstream keep the gate draining
    begin_test("drain");
    hold_rsp = 1'b1;
    run_traffic(NumHeld, 1'b0);
    isolate_i = 1'b1;
    @(posedge clk_i);
    #1;
    no_fwd = 1'b1;
    run_traffic(1, 1'b1);
    @(negedge clk_i);
    if (isolated_o)
      report_error("isolated_o high while responses are held downstream");
    @(posedge clk_i);
    #1;
    hold_rsp = 1'b0;
    do begin
      @(negedge clk_i);
    end while (!isolated_o);
    if (rd_outstanding != 0 || wr_outstanding != 0)
      report_error("isolated_o rose before every response reached the upstream port");
    @(posedge clk_i);
    #1;
    finish_test();

    begin_test("terminate");
    run_traffic(NumTraffic, 1'b1);
    wait_all_done();
    if (!isolated_o)
      report_error("isolated_o dropped while isolate_i stayed high");
    finish_test();

    begin_test("release");
    isolate_i = 1'b0;
    @(posedge clk_i);
    #1;
    no_fwd = 1'b0;
    if (isolated_o !== 1'b0)
      report_mismatch("isolated_o", 0, isolated_o);
    run_traffic(NumTraffic, 1'b0);
    wait_all_done();
    finish_test();

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
  Free-running clock for the testbench, 8 ns period by default.
*/
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PeriodNs = 8.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

endmodule

// ==== src/port_isolate.sv ====
/*
  Isolation gate for one memory-mapped port. Upstream s_ ports face the
  requester, downstream m_ ports face the target; isolate_i requests the
  drain and isolated_o confirms it.
*/
`timescale 1ns/1ps

module port_isolate
  import axil_pkg::*;
#(
  parameter int unsigned NumPending = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 isolate_i,
  output logic                 isolated_o,
  // Upstream write
  input  logic                 s_aw_valid_i,
  input  logic [AddrWidth-1:0] s_aw_addr_i,
  input  logic [IdWidth-1:0]   s_aw_id_i,
  input  logic [DataWidth-1:0] s_aw_data_i,
  output logic                 s_aw_ready_o,
  output logic                 s_b_valid_o,
  output logic [IdWidth-1:0]   s_b_id_o,
  output resp_t                s_b_resp_o,
  input  logic                 s_b_ready_i,
  // Downstream write
  output logic                 m_aw_valid_o,
  output logic [AddrWidth-1:0] m_aw_addr_o,
  output logic [IdWidth-1:0]   m_aw_id_o,
  output logic [DataWidth-1:0] m_aw_data_o,
  input  logic                 m_aw_ready_i,
  input  logic                 m_b_valid_i,
  input  logic [IdWidth-1:0]   m_b_id_i,
  input  resp_t                m_b_resp_i,
  output logic                 m_b_ready_o,
  // Upstream read
  input  logic                 s_ar_valid_i,
  input  logic [AddrWidth-1:0] s_ar_addr_i,
  input  logic [IdWidth-1:0]   s_ar_id_i,
  output logic                 s_ar_ready_o,
  output logic                 s_r_valid_o,
  output logic [IdWidth-1:0]   s_r_id_o,
  output logic [DataWidth-1:0] s_r_data_o,
  output resp_t                s_r_resp_o,
  input  logic                 s_r_ready_i,
  // Downstream read
  output logic                 m_ar_valid_o,
  output logic [AddrWidth-1:0] m_ar_addr_o,
  output logic [IdWidth-1:0]   m_ar_id_o,
  input  logic                 m_ar_ready_i,
  input  logic                 m_r_valid_i,
  input  logic [IdWidth-1:0]   m_r_id_i,
  input  logic [DataWidth-1:0] m_r_data_i,
  input  resp_t                m_r_resp_i,
  output logic                 m_r_ready_o
);

  logic block;
  logic wr_idle;
  logic rd_idle;

  // Bus ports share their names with the top level
  write_isolate #(
    .NumPending ( NumPending )
  ) i_write_isolate (
    .*,
    .block_i    ( block      ),
    .wr_idle_o  ( wr_idle    )
  );

  read_isolate #(
    .NumPending ( NumPending )
  ) i_read_isolate (
    .*,
    .block_i    ( block      ),
    .rd_idle_o  ( rd_idle    )
  );

  isolate_ctrl i_isolate_ctrl (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .isolate_i  ( isolate_i  ),
    .wr_idle_i  ( wr_idle    ),
    .rd_idle_i  ( rd_idle    ),
    .block_o    ( block      ),
    .isolated_o ( isolated_o )
  );

endmodule

// ==== src/isolate_ctrl.sv ====
/*
  Isolation controller. Blocks both paths once isolate_i is raised and
  reports isolated_o after both paths have drained.
*/
`timescale 1ns/1ps

module isolate_ctrl
  import isolate_cfg_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic isolate_i,
  input  logic wr_idle_i,
  input  logic rd_idle_i,
  output logic block_o,
  output logic isolated_o
);

  iso_state_t state_q;
  iso_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Normal: begin
        if (isolate_i) begin
          state_d = Drain;
        end
      end
      Drain: begin
        // Release wins over finishing the drain
        if (!isolate_i) begin
          state_d = Normal;
        end else if (wr_idle_i && rd_idle_i) begin
          state_d = Isolated;
        end
      end
      Isolated: begin
        if (!isolate_i) begin
          state_d = Normal;
        end
      end
      default: begin
        state_d = Normal;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Normal;
    end else begin
      state_q <= state_d;
    end
  end

  assign block_o    = (state_q != Normal);
  assign isolated_o = (state_q == Isolated);

endmodule

// ==== src/read_isolate.sv ====
/*
  Read path of the isolation gate. Passes reads through while open and
  counts outstanding ones; blocked reads are answered locally with an
  error response and zero data.
*/
`timescale 1ns/1ps

module read_isolate
  import axil_pkg::*;
  import isolate_cfg_pkg::*;
#(
  parameter int unsigned NumPending = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 block_i,
  // Upstream side
  input  logic                 s_ar_valid_i,
  input  logic [AddrWidth-1:0] s_ar_addr_i,
  input  logic [IdWidth-1:0]   s_ar_id_i,
  output logic                 s_ar_ready_o,
  output logic                 s_r_valid_o,
  output logic [IdWidth-1:0]   s_r_id_o,
  output logic [DataWidth-1:0] s_r_data_o,
  output resp_t                s_r_resp_o,
  input  logic                 s_r_ready_i,
  // Downstream side
  output logic                 m_ar_valid_o,
  output logic [AddrWidth-1:0] m_ar_addr_o,
  output logic [IdWidth-1:0]   m_ar_id_o,
  input  logic                 m_ar_ready_i,
  input  logic                 m_r_valid_i,
  input  logic [IdWidth-1:0]   m_r_id_i,
  input  logic [DataWidth-1:0] m_r_data_i,
  input  resp_t                m_r_resp_i,
  output logic                 m_r_ready_o,
  output logic                 rd_idle_o
);

  localparam int unsigned CntWidth = pend_cnt_width(NumPending);

  logic [CntWidth-1:0] cnt_q;
  logic                cnt_full;
  logic                req_fwd;
  logic                rsp_fwd;
  logic                err_valid_q;
  logic [IdWidth-1:0]  err_id_q;
  logic                err_take;
  logic                err_pop;

  assign cnt_full = (cnt_q == CntWidth'(NumPending));

  assign m_ar_valid_o = s_ar_valid_i & ~block_i & ~cnt_full;
  assign m_ar_addr_o  = s_ar_addr_i;
  assign m_ar_id_o    = s_ar_id_i;
  assign s_ar_ready_o = block_i ? ~err_valid_q : (m_ar_ready_i & ~cnt_full);

  assign req_fwd  = m_ar_valid_o & m_ar_ready_i;
  assign err_take = block_i & s_ar_valid_i & ~err_valid_q;

  // Local error waits for any downstream beat
  assign s_r_valid_o = m_r_valid_i | err_valid_q;
  assign s_r_id_o    = m_r_valid_i ? m_r_id_i : err_id_q;
  assign s_r_data_o  = m_r_valid_i ? m_r_data_i : '0;
  assign s_r_resp_o  = m_r_valid_i ? m_r_resp_i : RespSlvErr;
  assign m_r_ready_o = s_r_ready_i;

  assign rsp_fwd = m_r_valid_i & s_r_ready_i;
  assign err_pop = err_valid_q & ~m_r_valid_i & s_r_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (req_fwd != rsp_fwd) begin
      cnt_q <= req_fwd ? cnt_q + CntWidth'(1) : cnt_q - CntWidth'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_valid_q <= 1'b0;
    end else if (err_take) begin
      err_valid_q <= 1'b1;
    end else if (err_pop) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_take) begin
      err_id_q <= s_ar_id_i;
    end
  end

  assign rd_idle_o = (cnt_q == '0) & ~err_valid_q;

  rd_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= CntWidth'(NumPending))
    else $error("read pending count above limit");

  rd_no_orphan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_r_valid_i |-> cnt_q != '0)
    else $error("downstream read response with nothing outstanding");

endmodule

// ==== src/write_isolate.sv ====
/*
  Write path of the isolation gate. Forwards requests while open and
  tracks outstanding writes; while blocked, requests are accepted here
  and answered with a local error response.
*/
`timescale 1ns/1ps

module write_isolate
  import axil_pkg::*;
  import isolate_cfg_pkg::*;
#(
  parameter int unsigned NumPending = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 block_i,
  // Upstream side
  input  logic                 s_aw_valid_i,
  input  logic [AddrWidth-1:0] s_aw_addr_i,
  input  logic [IdWidth-1:0]   s_aw_id_i,
  input  logic [DataWidth-1:0] s_aw_data_i,
  output logic                 s_aw_ready_o,
  output logic                 s_b_valid_o,
  output logic [IdWidth-1:0]   s_b_id_o,
  output resp_t                s_b_resp_o,
  input  logic                 s_b_ready_i,
  // Downstream side
  output logic                 m_aw_valid_o,
  output logic [AddrWidth-1:0] m_aw_addr_o,
  output logic [IdWidth-1:0]   m_aw_id_o,
  output logic [DataWidth-1:0] m_aw_data_o,
  input  logic                 m_aw_ready_i,
  input  logic                 m_b_valid_i,
  input  logic [IdWidth-1:0]   m_b_id_i,
  input  resp_t                m_b_resp_i,
  output logic                 m_b_ready_o,
  output logic                 wr_idle_o
);

  localparam int unsigned CntWidth = pend_cnt_width(NumPending);

  logic [CntWidth-1:0] cnt_q;
  logic                cnt_full;
  logic                req_fwd;
  logic                rsp_fwd;
  logic                err_valid_q;
  logic [IdWidth-1:0]  err_id_q;
  logic                err_take;
  logic                err_pop;

  assign cnt_full = (cnt_q == CntWidth'(NumPending));

  // Request channel, zero latency while open
  assign m_aw_valid_o = s_aw_valid_i & ~block_i & ~cnt_full;
  assign m_aw_addr_o  = s_aw_addr_i;
  assign m_aw_id_o    = s_aw_id_i;
  assign m_aw_data_o  = s_aw_data_i;
  assign s_aw_ready_o = block_i ? ~err_valid_q : (m_aw_ready_i & ~cnt_full);

  assign req_fwd  = m_aw_valid_o & m_aw_ready_i;
  assign err_take = block_i & s_aw_valid_i & ~err_valid_q;

  // Drained responses win over the local one
  assign s_b_valid_o = m_b_valid_i | err_valid_q;
  assign s_b_id_o    = m_b_valid_i ? m_b_id_i : err_id_q;
  assign s_b_resp_o  = m_b_valid_i ? m_b_resp_i : RespSlvErr;
  assign m_b_ready_o = s_b_ready_i;

  assign rsp_fwd = m_b_valid_i & s_b_ready_i;
  assign err_pop = err_valid_q & ~m_b_valid_i & s_b_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (req_fwd != rsp_fwd) begin
      cnt_q <= req_fwd ? cnt_q + CntWidth'(1) : cnt_q - CntWidth'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_valid_q <= 1'b0;
    end else if (err_take) begin
      err_valid_q <= 1'b1;
    end else if (err_pop) begin
      err_valid_q <= 1'b0;
    end
  end

  // Write data of a terminated request is dropped
  always_ff @(posedge clk_i) begin
    if (err_take) begin
      err_id_q <= s_aw_id_i;
    end
  end

  assign wr_idle_o = (cnt_q == '0) & ~err_valid_q;

  wr_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= CntWidth'(NumPending))
    else $error("write pending count above limit");

  wr_no_orphan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_b_valid_i |-> cnt_q != '0)
    else $error("downstream write response with nothing outstanding");

endmodule

// ==== src/isolate_cfg_pkg.sv ====
/*
  Isolation state encoding and sizing of the pending counters.
  Shared by the isolation controller and the two path isolators.
*/
package isolate_cfg_pkg;

  typedef enum logic [1:0] {
    Normal   = 2'd0,
    Drain    = 2'd1,
    Isolated = 2'd2
  } iso_state_t;

  // Counter holds every value from zero up to the limit itself
  function automatic int unsigned pend_cnt_width(input int unsigned limit);
    return $clog2(limit) + 1;
  endfunction

endpackage

// ==== src/axil_pkg.sv ====
/*
  Field widths and response codes of the single-beat memory port.
  Imported by both path isolators, the top level and the testbench.
*/
package axil_pkg;

  // Request and response fields
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;

  typedef logic [1:0] resp_t;

  // Normal completion from the downstream side
  localparam resp_t RespOkay   = 2'b00;

  // Answer for anything terminated inside the gate
  localparam resp_t RespSlvErr = 2'b10;

endpackage
